// ==== async_fifo_pkg.sv ====
package async_fifo_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // fifo geometry
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int DATA_WIDTH  = 8;
  localparam int FIFO_DEPTH  = 16;
  localparam int ADDR_WIDTH  = $clog2(FIFO_DEPTH); // pointers carry one extra wrap bit.
  localparam int FIFO_AFULL  = FIFO_DEPTH - 1;
  localparam int FIFO_AEMPTY = 1;
  localparam int SYNC_STAGES = 2;                  // flops per crossing.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // pointer code conversion
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [ADDR_WIDTH:0] bin2gray(input logic [ADDR_WIDTH:0] bin);
    return (bin >> 1) ^ bin;
  endfunction

  function automatic logic [ADDR_WIDTH:0] gray2bin(input logic [ADDR_WIDTH:0] gray);
    logic [ADDR_WIDTH:0] bin;
    bin[ADDR_WIDTH] = gray[ADDR_WIDTH];
    for (int i = ADDR_WIDTH - 1; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i]; // running xor from the msb down.
    end
    return bin;
  endfunction

endpackage

// ==== dualport_ram_async.sv ====
`timescale 1ns/1ps

module dualport_ram_async
  import async_fifo_pkg::*;
(
  // write port
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  ram_wr_en,
  input  logic [ADDR_WIDTH-1:0] ram_wr_addr,
  input  logic [DATA_WIDTH-1:0] wr_data,
  // read port
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  ram_rd_en,
  input  logic [ADDR_WIDTH-1:0] ram_rd_addr,
  output logic [DATA_WIDTH-1:0] rd_data
);

  logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // write side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge wr_clk) begin
    if (wr_rst_n && ram_wr_en) begin // no stores while the write domain is held.
      mem[ram_wr_addr] <= wr_data;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // The output register only loads on an accepted read, so rd_data
  // holds the last word while the FIFO sits empty.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (ram_rd_en) begin
      rd_data <= mem[ram_rd_addr]; // one cycle read latency.
    end
  end

endmodule

// ==== fifo_wr_ctrl.sv ====
`timescale 1ns/1ps

module fifo_wr_ctrl
  import async_fifo_pkg::*;
(
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  wr_en,
  input  logic [ADDR_WIDTH:0]   rd_ptr_gray,
  output logic                  ram_wr_en,
  output logic [ADDR_WIDTH-1:0] ram_wr_addr,
  output logic [ADDR_WIDTH:0]   wr_ptr_gray,
  output logic                  full,
  output logic                  afull
);

  logic                wr_vld;
  logic [ADDR_WIDTH:0] wr_bin;
  logic [ADDR_WIDTH:0] wr_bin_nxt;
  logic [ADDR_WIDTH:0] wr_gray_nxt;
  logic [ADDR_WIDTH:0] rd_gray_sync [SYNC_STAGES];
  logic [ADDR_WIDTH:0] rd_gray_wsyn;
  logic [ADDR_WIDTH:0] rd_bin_wsyn;
  logic [ADDR_WIDTH:0] full_match;
  logic [ADDR_WIDTH:0] used_nxt;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // write pointer
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign wr_vld      = wr_en && !full;   // writes while full are dropped.
  assign wr_bin_nxt  = wr_bin + (ADDR_WIDTH + 1)'(wr_vld);
  assign wr_gray_nxt = bin2gray(wr_bin_nxt);

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_bin      <= '0;
      wr_ptr_gray <= '0;
    end else begin
      wr_bin      <= wr_bin_nxt;
      wr_ptr_gray <= wr_gray_nxt; // only this word leaves the domain.
    end
  end

  assign ram_wr_en   = wr_vld;
  assign ram_wr_addr = wr_bin[ADDR_WIDTH-1:0];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read pointer synchronizer
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        rd_gray_sync[i] <= '0;
      end
    end else begin
      rd_gray_sync[0] <= rd_ptr_gray; // first stage may go metastable.
      for (int i = 1; i < SYNC_STAGES; i++) begin
        rd_gray_sync[i] <= rd_gray_sync[i-1];
      end
    end
  end

  assign rd_gray_wsyn = rd_gray_sync[SYNC_STAGES-1];
  assign rd_bin_wsyn  = gray2bin(rd_gray_wsyn);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // flags
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // In Gray code a pointer one lap ahead differs in the two top bits.
  assign full_match = {~rd_gray_wsyn[ADDR_WIDTH:ADDR_WIDTH-1],
                       rd_gray_wsyn[ADDR_WIDTH-2:0]};
  assign used_nxt   = wr_bin_nxt - rd_bin_wsyn; // stale read pointer, so never low.

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      full  <= 1'b0;
      afull <= 1'b0;
    end else begin
      full  <= (wr_gray_nxt == full_match);
      afull <= (used_nxt >= (ADDR_WIDTH + 1)'(FIFO_AFULL));
    end
  end

endmodule

// ==== fifo_rd_ctrl.sv ====
`timescale 1ns/1ps

module fifo_rd_ctrl
  import async_fifo_pkg::*;
(
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_en,
  input  logic [ADDR_WIDTH:0]   wr_ptr_gray,
  output logic                  ram_rd_en,
  output logic [ADDR_WIDTH-1:0] ram_rd_addr,
  output logic [ADDR_WIDTH:0]   rd_ptr_gray,
  output logic                  empty,
  output logic                  aempty
);

  logic                rd_vld;
  logic [ADDR_WIDTH:0] rd_bin;
  logic [ADDR_WIDTH:0] rd_bin_nxt;
  logic [ADDR_WIDTH:0] rd_gray_nxt;
  logic [ADDR_WIDTH:0] wr_gray_sync [SYNC_STAGES];
  logic [ADDR_WIDTH:0] wr_gray_rsyn;
  logic [ADDR_WIDTH:0] wr_bin_rsyn;
  logic [ADDR_WIDTH:0] used_nxt;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read pointer
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign rd_vld      = rd_en && !empty;  // reads while empty are ignored.
  assign rd_bin_nxt  = rd_bin + (ADDR_WIDTH + 1)'(rd_vld);
  assign rd_gray_nxt = bin2gray(rd_bin_nxt);

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_bin      <= '0;
      rd_ptr_gray <= '0;
    end else begin
      rd_bin      <= rd_bin_nxt;
      rd_ptr_gray <= rd_gray_nxt;
    end
  end

  // the ram latches the word at the current address on this same edge.
  assign ram_rd_en   = rd_vld;
  assign ram_rd_addr = rd_bin[ADDR_WIDTH-1:0];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // write pointer synchronizer
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        wr_gray_sync[i] <= '0;
      end
    end else begin
      wr_gray_sync[0] <= wr_ptr_gray;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        wr_gray_sync[i] <= wr_gray_sync[i-1];
      end
    end
  end

  assign wr_gray_rsyn = wr_gray_sync[SYNC_STAGES-1];
  assign wr_bin_rsyn  = gray2bin(wr_gray_rsyn);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // flags
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign used_nxt = wr_bin_rsyn - rd_bin_nxt; // lagging write pointer, never high.

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      empty  <= 1'b1;
      aempty <= 1'b1;
    end else begin
      empty  <= (rd_gray_nxt == wr_gray_rsyn); // equal pointers, nothing stored.
      aempty <= (used_nxt <= (ADDR_WIDTH + 1)'(FIFO_AEMPTY));
    end
  end

endmodule

// ==== async_fifo.sv ====
`timescale 1ns/1ps

module async_fifo
  import async_fifo_pkg::*;
(
  // write domain
  input  logic                  wr_clk,
  input  logic                  wr_rst_n,
  input  logic                  wr_en,
  input  logic [DATA_WIDTH-1:0] wr_data,
  output logic                  full,
  output logic                  afull,
  // read domain
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  input  logic                  rd_en,
  output logic [DATA_WIDTH-1:0] rd_data,
  output logic                  empty,
  output logic                  aempty
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // internal wiring
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  logic [ADDR_WIDTH:0]   wr_ptr_gray;   // crosses into rd_clk.
  logic [ADDR_WIDTH:0]   rd_ptr_gray;   // crosses into wr_clk.
  logic                  ram_wr_en;
  logic [ADDR_WIDTH-1:0] ram_wr_addr;
  logic                  ram_rd_en;
  logic [ADDR_WIDTH-1:0] ram_rd_addr;

  fifo_wr_ctrl wr_ctrl_i (
    .wr_clk      (wr_clk),
    .wr_rst_n    (wr_rst_n),
    .wr_en       (wr_en),
    .rd_ptr_gray (rd_ptr_gray),
    .ram_wr_en   (ram_wr_en),
    .ram_wr_addr (ram_wr_addr),
    .wr_ptr_gray (wr_ptr_gray),
    .full        (full),
    .afull       (afull)
  );

  dualport_ram_async ram_i (
    .wr_clk      (wr_clk),
    .wr_rst_n    (wr_rst_n),
    .ram_wr_en   (ram_wr_en),
    .ram_wr_addr (ram_wr_addr),
    .wr_data     (wr_data),
    .rd_clk      (rd_clk),
    .rd_rst_n    (rd_rst_n),
    .ram_rd_en   (ram_rd_en),
    .ram_rd_addr (ram_rd_addr),
    .rd_data     (rd_data)
  );

  fifo_rd_ctrl rd_ctrl_i (
    .rd_clk      (rd_clk),
    .rd_rst_n    (rd_rst_n),
    .rd_en       (rd_en),
    .wr_ptr_gray (wr_ptr_gray),
    .ram_rd_en   (ram_rd_en),
    .ram_rd_addr (ram_rd_addr),
    .rd_ptr_gray (rd_ptr_gray),
    .empty       (empty),
    .aempty      (aempty)
  );

endmodule

// ==== async_fifo_chk.sv ====
`timescale 1ns/1ps

module async_fifo_chk (
  input logic wr_clk,
  input logic wr_rst_n,
  input logic rd_clk,
  input logic rd_rst_n,
  input logic full,
  input logic afull,
  input logic empty,
  input logic aempty
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // flag consistency
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  full_implies_afull: assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n) full |-> afull
  ) else $error("full is set while afull is clear");

  empty_implies_aempty: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n) empty |-> aempty
  ) else $error("empty is set while aempty is clear");

  full_known: assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n) !$isunknown(full)
  ) else $error("full is unknown outside reset");

  empty_known: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n) !$isunknown(empty)
  ) else $error("empty is unknown outside reset");

endmodule

bind async_fifo async_fifo_chk chk_i (.*);

// ==== async_fifo_tb.sv ====
`timescale 1ns/1ps

module async_fifo_tb
  import async_fifo_pkg::*;
;

  localparam int WR_HALF         = 10;
  localparam int RD_HALF         = 14;
  localparam int RD_PERIOD       = 2 * RD_HALF;
  localparam int NUM_RAND_WRITES = 200;
  localparam int RD_PAT_LEN      = 256;
  localparam int SETTLE          = SYNC_STAGES + 3;  // cycles for a crossing to land.
  localparam int TOTAL_WORDS     = 2 * (FIFO_DEPTH + 4) + 2 * (FIFO_DEPTH + 2)
                                   + NUM_RAND_WRITES + FIFO_DEPTH;
  localparam int WATCHDOG_NS     = TOTAL_WORDS * 4 * RD_PERIOD
                                   + 10 * SETTLE * RD_PERIOD;

  logic                  wr_clk;
  logic                  wr_rst_n;
  logic                  wr_en;
  logic [DATA_WIDTH-1:0] wr_data;
  logic                  full;
  logic                  afull;
  logic                  rd_clk;
  logic                  rd_rst_n;
  logic                  rd_en;
  logic [DATA_WIDTH-1:0] rd_data;
  logic                  empty;
  logic                  aempty;

  logic [31:0]           lfsr = 32'h7f70;
  logic [DATA_WIDTH-1:0] ref_q [$];          // words written but not yet read.
  logic [DATA_WIDTH-1:0] rd_expect;
  logic [DATA_WIDTH-1:0] last_popped = '0;
  logic                  rd_pending = 1'b0;
  int                    err_count = 0;
  int                    check_count = 0;
  string                 test_name = "none";

  async_fifo dut_i (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .full     (full),
    .afull    (afull),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .empty    (empty),
    .aempty   (aempty)
  );

  initial begin
    wr_clk = 1'b0;
    forever #(WR_HALF) wr_clk = ~wr_clk;
  end

  initial begin
    rd_clk = 1'b0;
    forever #(RD_HALF) rd_clk = ~rd_clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // fibonacci lfsr, taps 32 22 2 1.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      val  = {val[30:0], fb};
    end
    return val;
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    check_count++;
    assert (act === exp) else begin
      $display("CHECK FAILED %s %s: expected %0h, actual %0h", test_name, what, exp, act);
      err_count++;
    end
  endtask

  task automatic expect_true(input logic cond, input string msg);
    check_count++;
    assert (cond === 1'b1) else begin
      $display("ERROR in %s: %s", test_name, msg);
      err_count++;
    end
  endtask

  // reads the fifo until empty rises, with the write side idle.
  task automatic drain_fifo();
    int cycles;
    cycles = 0;
    repeat (SETTLE) @(posedge rd_clk);
    do begin
      @(posedge rd_clk);
      rd_en <= 1'b1;
      @(negedge rd_clk);
      cycles++;
    end while (!empty && cycles < FIFO_DEPTH + 4);
    @(posedge rd_clk);
    rd_en <= 1'b0;
    @(negedge rd_clk);
    expect_true(empty, "empty never rose while draining the FIFO");
    check_value("words left in reference queue", 0, ref_q.size());
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sampled at the falling edge, ahead of the accepting rising edge.
  always @(negedge wr_clk) begin
    if (wr_rst_n && wr_en && !full) begin
      ref_q.push_back(wr_data);
    end
  end

  always @(negedge rd_clk) begin
    if (rd_pending) begin
      check_value("rd_data", rd_expect, rd_data); // word from the previous edge.
      rd_pending = 1'b0;
    end
    if (rd_rst_n && rd_en && !empty) begin
      expect_true(ref_q.size() > 0, "read accepted while no word was written");
      if (ref_q.size() > 0) begin
        rd_expect   = ref_q.pop_front();
        last_popped = rd_expect;
        rd_pending  = 1'b1;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic reset_state_test();
    test_name = "reset_state";
    @(negedge wr_clk);
    check_value("full", 0, full);
    check_value("afull", 0, afull);
    @(negedge rd_clk);
    check_value("empty", 1, empty);
    check_value("aempty", 1, aempty);
    check_value("rd_data", 0, rd_data);
  endtask

  task automatic fill_test();
    int n_acc;
    test_name = "fill";
    n_acc = 0;
    for (int i = 0; i < FIFO_DEPTH + 4; i++) begin
      @(posedge wr_clk);
      wr_en   <= 1'b1;
      wr_data <= DATA_WIDTH'(rand_bits(DATA_WIDTH));
      @(negedge wr_clk);
      check_value("full", 32'(n_acc >= FIFO_DEPTH), full);
      check_value("afull", 32'(n_acc >= FIFO_AFULL), afull);
      if (!full) n_acc++;
    end
    @(posedge wr_clk);
    wr_en <= 1'b0;
    check_value("accepted writes", FIFO_DEPTH, n_acc);
  endtask

  task automatic drain_test();
    int n_rd;
    test_name = "drain";
    n_rd = 0;
    repeat (SETTLE) @(posedge rd_clk);
    for (int i = 0; i < FIFO_DEPTH + 3; i++) begin
      @(posedge rd_clk);
      rd_en <= 1'b1;
      @(negedge rd_clk);
      check_value("empty", 32'(n_rd >= FIFO_DEPTH), empty);
      check_value("aempty", 32'(FIFO_DEPTH - n_rd <= FIFO_AEMPTY), aempty);
      if (!empty) n_rd++;
    end
    @(posedge rd_clk);
    rd_en <= 1'b0;
    @(negedge rd_clk);
    check_value("accepted reads", FIFO_DEPTH, n_rd);
    check_value("rd_data after empty reads", last_popped, rd_data); // must hold.
  endtask

  task automatic flag_release_test();
    int cycles;
    test_name = "flag_release";
    // one write into the empty fifo.
    @(posedge wr_clk);
    wr_en   <= 1'b1;
    wr_data <= DATA_WIDTH'(rand_bits(DATA_WIDTH));
    @(posedge wr_clk);
    wr_en <= 1'b0;
    cycles = 0;
    do begin
      @(negedge rd_clk);
      cycles++;
    end while (empty && cycles < SYNC_STAGES + 3);
    expect_true(!empty && cycles <= SYNC_STAGES + 2,
      $sformatf("empty did not fall within %0d rd_clk cycles", SYNC_STAGES + 2));
    @(posedge rd_clk);
    rd_en <= 1'b1;
    @(posedge rd_clk);
    rd_en <= 1'b0;

    // refill, then one read out of the full fifo.
    repeat (SETTLE) @(posedge wr_clk);
    cycles = 0;
    do begin
      @(posedge wr_clk);
      wr_en   <= 1'b1;
      wr_data <= DATA_WIDTH'(rand_bits(DATA_WIDTH));
      @(negedge wr_clk);
      cycles++;
    end while (!full && cycles < FIFO_DEPTH + 8);
    @(posedge wr_clk);
    wr_en <= 1'b0;
    expect_true(full, "full did not rise while refilling");
    repeat (SETTLE) @(posedge rd_clk);
    @(posedge rd_clk);
    rd_en <= 1'b1;
    @(posedge rd_clk);
    rd_en <= 1'b0;
    cycles = 0;
    do begin
      @(negedge wr_clk);
      cycles++;
    end while (full && cycles < SYNC_STAGES + 3);
    expect_true(!full && cycles <= SYNC_STAGES + 2,
      $sformatf("full did not fall within %0d wr_clk cycles", SYNC_STAGES + 2));
    drain_fifo();
  endtask

  task automatic random_traffic_test();
    logic                  wr_pat   [NUM_RAND_WRITES];
    logic [DATA_WIDTH-1:0] data_pat [NUM_RAND_WRITES];
    logic                  rd_pat   [RD_PAT_LEN];
    logic                  writer_done;
    test_name   = "random_traffic";
    writer_done = 1'b0;
    for (int i = 0; i < NUM_RAND_WRITES; i++) begin
      wr_pat[i]   = 1'(rand_bits(1));
      data_pat[i] = DATA_WIDTH'(rand_bits(DATA_WIDTH));
    end
    for (int j = 0; j < RD_PAT_LEN; j++) begin
      rd_pat[j] = 1'(rand_bits(1) | rand_bits(1)); // reads three times in four.
    end
    fork
      begin
        for (int i = 0; i < NUM_RAND_WRITES; i++) begin
          @(posedge wr_clk);
          wr_en   <= wr_pat[i];
          wr_data <= data_pat[i];
        end
        @(posedge wr_clk);
        wr_en <= 1'b0;
        writer_done = 1'b1;
      end
      begin
        int j;
        j = 0;
        while (!writer_done) begin
          @(posedge rd_clk);
          rd_en <= rd_pat[j % RD_PAT_LEN];
          j++;
        end
        @(posedge rd_clk);
        rd_en <= 1'b0;
      end
    join
    drain_fifo();
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // main sequence and watchdog
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    wr_rst_n = 1'b0;
    rd_rst_n = 1'b0;
    wr_en    = 1'b0;
    wr_data  = '0;
    rd_en    = 1'b0;
    fork
      begin
        repeat (3) @(posedge wr_clk);
        wr_rst_n <= 1'b1;
      end
      begin
        repeat (3) @(posedge rd_clk);
        rd_rst_n <= 1'b1;
      end
    join
    reset_state_test();
    fill_test();
    drain_test();
    flag_release_test();
    random_traffic_test();
    $display("checks: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("TIMEOUT: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("Something failed");
    $finish;
  end

endmodule

// ==== verilog.f ====
async_fifo_pkg.sv
dualport_ram_async.sv
fifo_wr_ctrl.sv
fifo_rd_ctrl.sv
async_fifo.sv
async_fifo_chk.sv
async_fifo_tb.sv
